//--- common/fetch_pkg.sv
package fetch_pkg;

    // byte address of the 64-bit core
    typedef logic [63:0] addr_t;

    // one uncompressed instruction
    typedef logic [31:0] inst_t;

    // one memory word as stored in the instruction memory
    typedef logic [63:0] mem_word_t;

    // same 64 bits seen as a doubleword or as two instruction slots
    typedef union packed {
        mem_word_t  dword;
        inst_t [1:0] slot;
    } fetch_word_u;

    // address bit that picks the slot inside a memory word
    localparam int SLOT_SEL_BIT = 2;

    // first instruction after reset
    localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

endpackage

//--- common/redirect_pkg.sv
package redirect_pkg;

    // where the next pc comes from
    typedef enum logic [1:0] {
        REDIR_SEQ      = 2'd0,
        REDIR_JUMP     = 2'd1,
        REDIR_INDIRECT = 2'd2,
        REDIR_TRAP     = 2'd3
    } redirect_e;

    // jump beats jalr, jalr beats trap
    function automatic redirect_e select_redirect(
        input logic jump,
        input logic indirect,
        input logic trap
    );
        redirect_e sel;
        if (jump) begin
            sel = REDIR_JUMP;
        end else if (indirect) begin
            sel = REDIR_INDIRECT;
        end else if (trap) begin
            sel = REDIR_TRAP;
        end else begin
            sel = REDIR_SEQ;
        end
        return sel;
    endfunction

endpackage

//--- common/imem_rd_if.sv
`timescale 1ns/1ns

interface imem_rd_if;
    import fetch_pkg::*;

    // address phase
    logic        req_valid;
    addr_t       req_addr;
    logic        req_ready;

    // data phase
    logic        resp_valid;
    fetch_word_u resp_data;
    logic        resp_ready;

    // fetch side
    modport requester (
        output req_valid,
        output req_addr,
        input  req_ready,
        input  resp_valid,
        input  resp_data,
        output resp_ready
    );

    // memory side
    modport responder (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output resp_valid,
        output resp_data,
        input  resp_ready
    );

endinterface

//--- fetch/pc_gen.sv
`timescale 1ns/1ns

module pc_gen (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             advance_i,
    input  logic             jal_i,
    input  logic             branch_i,
    input  logic             jalr_i,
    input  logic             trap_i,
    input  fetch_pkg::addr_t alu_res_i,
    input  fetch_pkg::addr_t ex_pc_i,
    input  fetch_pkg::addr_t imm_i,
    input  fetch_pkg::addr_t rs1_data_i,
    input  fetch_pkg::addr_t mtvec_i,
    output fetch_pkg::addr_t pc_o,
    output logic             redirect_o
);
    import fetch_pkg::*;
    import redirect_pkg::*;

    redirect_e pc_sel;
    addr_t     pc_q;
    addr_t     pc_next;
    addr_t     jump_target;
    addr_t     indirect_sum;
    addr_t     indirect_target;
    logic      take_jump;

    // branch condition comes from the alu compare result
    assign take_jump = jal_i || (branch_i && (alu_res_i == '0));

    assign jump_target     = ex_pc_i + imm_i;
    assign indirect_sum    = rs1_data_i + imm_i;
    // jalr clears the lowest target bit
    assign indirect_target = {indirect_sum[63:1], 1'b0};

    assign pc_sel = select_redirect(take_jump, jalr_i, trap_i);

    always_comb begin
        case (pc_sel)
            REDIR_JUMP:     pc_next = jump_target;
            REDIR_INDIRECT: pc_next = indirect_target;
            REDIR_TRAP:     pc_next = mtvec_i;
            default:        pc_next = advance_i ? pc_q + 64'd4 : pc_q;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o       = pc_q;
    assign redirect_o = (pc_sel != REDIR_SEQ);

    // targets supplied by execute and csr must stay halfword aligned
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !pc_o[0]
    ) else $error("pc_gen: odd pc %h", pc_o);

endmodule

//--- fetch/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             stall_i,
    input  fetch_pkg::addr_t pc_i,
    input  logic             redirect_i,
    imem_rd_if.requester     rd,
    output logic             advance_o,
    output fetch_pkg::inst_t inst_o,
    output fetch_pkg::addr_t pc_o,
    output logic             inst_valid_o
);
    import fetch_pkg::*;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1;
    localparam logic [1:0] S_RESP = 2'd2;

    logic [1:0] state_q;
    logic       hold_q;
    addr_t      addr_q;
    logic       req_fire;
    logic       resp_fire;
    logic       deliver;

    // one read at a time, address phase then data phase
    assign rd.req_valid  = (state_q == S_REQ);
    // first request cycle takes pc directly, later wait cycles replay the latch
    assign rd.req_addr   = hold_q ? addr_q : pc_i;
    assign rd.resp_ready = (state_q == S_RESP) && !stall_i;

    assign req_fire  = rd.req_valid && rd.req_ready;
    assign resp_fire = rd.resp_valid && rd.resp_ready;

    // a response counts only if it is still the pc we want
    assign deliver   = resp_fire && (addr_q == pc_i) && !redirect_i;
    assign advance_o = deliver;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            hold_q  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    state_q <= S_REQ;
                end
                S_REQ: begin
                    if (req_fire) begin
                        state_q <= S_RESP;
                        hold_q  <= 1'b0;
                    end else begin
                        hold_q  <= 1'b1;
                    end
                end
                S_RESP: begin
                    // stale or not, the response is consumed here
                    if (resp_fire) begin
                        state_q <= S_REQ;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // address of the outstanding request
    always_ff @(posedge clk) begin
        if (state_q == S_REQ) begin
            addr_q <= rd.req_addr;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= deliver;
        end
    end

    always_ff @(posedge clk) begin
        if (deliver) begin
            inst_o <= rd.resp_data.slot[addr_q[SLOT_SEL_BIT]];
            pc_o   <= addr_q;
        end
    end

    a_req_addr_stable: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        rd.req_valid && !rd.req_ready |=> rd.req_valid && $stable(rd.req_addr)
    ) else $error("fetch_ctrl: request changed before acceptance");

    // memory still holding a response means the previous read is open
    a_single_outstanding: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        rd.resp_valid |-> !rd.req_valid
    ) else $error("fetch_ctrl: request issued with a response pending");

endmodule

//--- hdl/imem_rom.sv
`timescale 1ns/1ns

module imem_rom #(
    parameter int IMEM_WORDS   = 256,
    parameter int IMEM_LATENCY = 2
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 load_en_i,
    input  fetch_pkg::addr_t     load_addr_i,
    input  fetch_pkg::mem_word_t load_data_i,
    imem_rd_if.responder         rd
);
    import fetch_pkg::*;

    localparam int IDX_W = (IMEM_WORDS > 1) ? $clog2(IMEM_WORDS) : 1;
    localparam int CNT_W = $clog2(IMEM_LATENCY + 1);

    mem_word_t        mem [IMEM_WORDS];
    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    addr_t            addr_q;
    logic [IDX_W-1:0] load_idx;
    logic [IDX_W-1:0] rd_idx;

    // word index, wrapping at the memory depth
    function automatic logic [IDX_W-1:0] word_index(input addr_t addr);
        return IDX_W'(addr[63:3] % IMEM_WORDS);
    endfunction

    assign load_idx = word_index(load_addr_i);
    assign rd_idx   = word_index(addr_q);

    // accept a new address only when idle
    assign rd.req_ready = !busy_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q        <= 1'b0;
            cnt_q         <= '0;
            rd.resp_valid <= 1'b0;
        end else if (rd.resp_valid) begin
            // hold until the requester takes it
            if (rd.resp_ready) begin
                rd.resp_valid <= 1'b0;
                busy_q        <= 1'b0;
            end
        end else if (busy_q) begin
            if (cnt_q == '0) begin
                rd.resp_valid <= 1'b1;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end else if (rd.req_valid) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(IMEM_LATENCY - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (load_en_i) begin
            mem[load_idx] <= load_data_i;
        end
        if (!busy_q && rd.req_valid) begin
            addr_q <= rd.req_addr;
        end
        // read on the last latency cycle
        if (busy_q && !rd.resp_valid && (cnt_q == '0)) begin
            rd.resp_data.dword <= mem[rd_idx];
        end
    end

    a_resp_held: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        rd.resp_valid && !rd.resp_ready |=> rd.resp_valid && $stable(rd.resp_data)
    ) else $error("imem_rom: response dropped before acceptance");

endmodule

//--- hdl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
    parameter int IMEM_WORDS   = 256,
    parameter int IMEM_LATENCY = 2
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 stall_i,
    input  logic                 jal_i,
    input  logic                 branch_i,
    input  logic                 jalr_i,
    input  logic                 trap_i,
    input  fetch_pkg::addr_t     alu_res_i,
    input  fetch_pkg::addr_t     ex_pc_i,
    input  fetch_pkg::addr_t     imm_i,
    input  fetch_pkg::addr_t     rs1_data_i,
    input  fetch_pkg::addr_t     mtvec_i,
    input  logic                 load_en_i,
    input  fetch_pkg::addr_t     load_addr_i,
    input  fetch_pkg::mem_word_t load_data_i,
    output fetch_pkg::inst_t     inst_o,
    output fetch_pkg::addr_t     pc_o,
    output logic                 inst_valid_o
);
    import fetch_pkg::*;

    addr_t fetch_pc;
    logic  redirect;
    logic  advance;

    imem_rd_if u_rd ();

    pc_gen u_pc_gen (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .advance_i  (advance),
        .jal_i      (jal_i),
        .branch_i   (branch_i),
        .jalr_i     (jalr_i),
        .trap_i     (trap_i),
        .alu_res_i  (alu_res_i),
        .ex_pc_i    (ex_pc_i),
        .imm_i      (imm_i),
        .rs1_data_i (rs1_data_i),
        .mtvec_i    (mtvec_i),
        .pc_o       (fetch_pc),
        .redirect_o (redirect)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .stall_i      (stall_i),
        .pc_i         (fetch_pc),
        .redirect_i   (redirect),
        .rd           (u_rd.requester),
        .advance_o    (advance),
        .inst_o       (inst_o),
        .pc_o         (pc_o),
        .inst_valid_o (inst_valid_o)
    );

    imem_rom #(
        .IMEM_WORDS   (IMEM_WORDS),
        .IMEM_LATENCY (IMEM_LATENCY)
    ) u_imem_rom (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .load_en_i   (load_en_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .rd          (u_rd.responder)
    );

endmodule

//--- verification/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;
    import fetch_pkg::*;

    localparam int IMEM_LATENCY = 2;
    localparam int LOAD_WORDS   = 64;
    localparam int TIMEOUT      = 50;

    logic      clk;
    logic      arst_n_i;
    logic      stall_i;
    logic      jal_i;
    logic      branch_i;
    logic      jalr_i;
    logic      trap_i;
    addr_t     alu_res_i;
    addr_t     ex_pc_i;
    addr_t     imm_i;
    addr_t     rs1_data_i;
    addr_t     mtvec_i;
    logic      load_en_i;
    addr_t     load_addr_i;
    mem_word_t load_data_i;
    inst_t     inst_o;
    addr_t     pc_o;
    logic      inst_valid_o;

    mem_word_t mem_model [LOAD_WORDS];
    addr_t     exp_pc;
    int        seed;
    int        errors;
    int        n_deliv;
    int        idle_cycles;

    fetch_top #(
        .IMEM_WORDS   (256),
        .IMEM_LATENCY (IMEM_LATENCY)
    ) u_dut (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .stall_i      (stall_i),
        .jal_i        (jal_i),
        .branch_i     (branch_i),
        .jalr_i       (jalr_i),
        .trap_i       (trap_i),
        .alu_res_i    (alu_res_i),
        .ex_pc_i      (ex_pc_i),
        .imm_i        (imm_i),
        .rs1_data_i   (rs1_data_i),
        .mtvec_i      (mtvec_i),
        .load_en_i    (load_en_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i),
        .inst_o       (inst_o),
        .pc_o         (pc_o),
        .inst_valid_o (inst_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic finish_run;
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // address of word slot k in the loaded program
    function automatic addr_t region_slot(input int k);
        return RESET_PC + addr_t'(k) * 64'd4;
    endfunction

    // advance one clock and check a delivery made on that edge
    task automatic tick;
        int        idx;
        mem_word_t word;
        inst_t     exp_inst;
        @(posedge clk);
        #1;
        if (!inst_valid_o) begin
            idle_cycles++;
        end else begin
            idle_cycles = 0;
            n_deliv++;
            idx = int'((exp_pc - RESET_PC) >> 3);
            word = mem_model[idx];
            exp_inst = exp_pc[2] ? word[63:32] : word[31:0];
            // stall_i still holds the level of the handshake cycle
            if (stall_i) begin
                $display("ERROR at %0t: instruction delivered while stall_i was high", $time);
                errors++;
            end
            if (pc_o !== exp_pc) begin
                $display("FAIL %0t pc_o expected %h got %h", $time, exp_pc, pc_o);
                errors++;
            end
            if (inst_o !== exp_inst) begin
                $display("FAIL %0t inst_o expected %h got %h", $time, exp_inst, inst_o);
                errors++;
            end
            exp_pc = exp_pc + 64'd4;
        end
    endtask

    task automatic wait_deliveries(input int n);
        int goal;
        goal = n_deliv + n;
        idle_cycles = 0;
        while (n_deliv < goal) begin
            tick();
            if (idle_cycles >= TIMEOUT) begin
                $display("ERROR at %0t: no instruction delivered within %0d cycles",
                         $time, TIMEOUT);
                errors++;
                finish_run();
            end
        end
    endtask

    // one-cycle redirect with the model pc following jump, then jalr, then trap
    task automatic apply_redirect(input logic jal, input logic branch, input logic alu_zero,
                                  input logic jalr, input logic trap);
        int r;
        int k;
        r = ($random(seed) % 128) * 4;
        k = $random(seed) & 63;
        // three different targets, none equal to the current pc
        if (region_slot(k) == exp_pc || region_slot((k + 21) & 63) == exp_pc ||
            region_slot((k + 42) & 63) == exp_pc) begin
            k = (k + 1) & 63;
        end
        imm_i = addr_t'(longint'(r));
        ex_pc_i = region_slot(k) - imm_i;
        // odd source so that the jalr bit clear matters
        rs1_data_i = region_slot((k + 21) & 63) - imm_i + 64'd1;
        mtvec_i = region_slot((k + 42) & 63);
        alu_res_i = alu_zero ? '0 : (addr_t'($random(seed)) | 64'd1);
        jal_i = jal;
        branch_i = branch;
        jalr_i = jalr;
        trap_i = trap;
        if (jal || (branch && alu_zero)) begin
            exp_pc = ex_pc_i + imm_i;
        end else if (jalr) begin
            exp_pc = (rs1_data_i + imm_i) & ~64'd1;
        end else if (trap) begin
            exp_pc = mtvec_i;
        end
        tick();
        jal_i = 1'b0;
        branch_i = 1'b0;
        jalr_i = 1'b0;
        trap_i = 1'b0;
    endtask

    task automatic run_random_traffic(input int cycles, input logic use_stall,
                                      input logic use_redirect);
        logic [4:0] flags;
        idle_cycles = 0;
        for (int i = 0; i < cycles; i++) begin
            flags = $random(seed);
            if (exp_pc - RESET_PC >= 64'd400) begin
                // stay inside the loaded words
                apply_redirect(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
            end else if (use_redirect && idle_cycles < 10 && ($random(seed) & 7) == 0) begin
                apply_redirect(flags[0], flags[1], flags[2], flags[3], flags[4]);
            end else begin
                tick();
            end
            if (use_stall) begin
                stall_i = ($random(seed) & 1) != 0;
            end
            if (idle_cycles >= TIMEOUT) begin
                $display("ERROR at %0t: deliveries stopped for %0d cycles", $time, TIMEOUT);
                errors++;
                finish_run();
            end
        end
        stall_i = 1'b0;
    endtask

    initial begin
        seed = 61;
        errors = 0;
        n_deliv = 0;
        idle_cycles = 0;
        exp_pc = RESET_PC;
        arst_n_i = 1'b0;
        stall_i = 1'b0;
        jal_i = 1'b0;
        branch_i = 1'b0;
        jalr_i = 1'b0;
        trap_i = 1'b0;
        alu_res_i = '0;
        ex_pc_i = '0;
        imm_i = '0;
        rs1_data_i = '0;
        mtvec_i = '0;
        load_en_i = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;

        // program load while the dut sits in reset
        for (int k = 0; k < LOAD_WORDS; k++) begin
            @(posedge clk);
            #1;
            load_en_i = 1'b1;
            load_addr_i = RESET_PC + addr_t'(k) * 64'd8;
            load_data_i = {$random(seed), $random(seed)};
            mem_model[k] = load_data_i;
        end
        @(posedge clk);
        #1;
        load_en_i = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n_i = 1'b1;

        wait_deliveries(12);
        apply_redirect(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        wait_deliveries(3);
        apply_redirect(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        wait_deliveries(3);
        // branch not taken
        apply_redirect(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        wait_deliveries(3);
        apply_redirect(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        wait_deliveries(3);
        apply_redirect(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        wait_deliveries(3);
        apply_redirect(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        wait_deliveries(3);
        run_random_traffic(80, 1'b1, 1'b0);
        run_random_traffic(300, 1'b1, 1'b1);
        finish_run();
    end

endmodule

//--- fetch_top.f
common/fetch_pkg.sv
common/redirect_pkg.sv
common/imem_rd_if.sv
fetch/pc_gen.sv
fetch/fetch_ctrl.sv
hdl/imem_rom.sv
hdl/fetch_top.sv
verification/fetch_tb.sv
